// ==== flist.f ====
logic/rename_pkg.sv
logic/map_table.sv
logic/free_list.sv
logic/reorder_buffer.sv
logic/completion_select.sv
logic/rename_core.sv
tests/rename_core_tb.sv

// ==== Bender.yml ====
package:
  name: rename_core

sources:
  - logic/rename_pkg.sv
  - logic/map_table.sv
  - logic/free_list.sv
  - logic/reorder_buffer.sv
  - logic/completion_select.sv
  - logic/rename_core.sv
  - target: test
    files:
      - tests/rename_core_tb.sv

// ==== tests/rename_core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_core_tb;

  // about four times the stimulus length
  localparam int cycle_limit = 2000;

  logic                          clock;
  logic                          reset;
  logic                          dispatch_valid;
  logic                          dispatch_ready;
  rename_pkg::arch_reg_t         dispatch_dest;
  rename_pkg::arch_reg_t         dispatch_src_a;
  rename_pkg::arch_reg_t         dispatch_src_b;
  rename_pkg::phys_tag_t         src_a_tag;
  rename_pkg::phys_tag_t         src_b_tag;
  logic                          src_a_ready;
  logic                          src_b_ready;
  rename_pkg::phys_tag_t         new_tag;
  rename_pkg::phys_tag_t         old_tag;
  logic [rename_pkg::num_fu-1:0] fu_done_valid;
  rename_pkg::phys_tag_t         fu_done_tag [rename_pkg::num_fu];
  logic [rename_pkg::num_fu-1:0] fu_done_ready;
  logic                          cdb_valid;
  rename_pkg::phys_tag_t         cdb_tag;
  logic                          retire_valid;
  rename_pkg::arch_reg_t         retire_arch;
  rename_pkg::phys_tag_t         retire_new_tag;
  rename_pkg::phys_tag_t         retire_old_tag;

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  rename_pkg::phys_tag_t                model_map [rename_pkg::num_arch_regs];
  logic [rename_pkg::num_phys_regs-1:0] model_ready;
  logic                                 model_started;
  rename_pkg::phys_tag_t                free_q [$];
  // rob as parallel queues, oldest first
  rename_pkg::arch_reg_t                rob_arch [$];
  rename_pkg::phys_tag_t                rob_new [$];
  rename_pkg::phys_tag_t                rob_old [$];
  rename_pkg::rob_state_t               rob_st [$];
  // dispatched tags no unit has picked up yet
  rename_pkg::phys_tag_t                pending [$];

  // expected values, stable from falling edge to rising edge
  logic                          exp_dispatch_ready;
  logic                          exp_fire = 1'b0;
  rename_pkg::phys_tag_t         exp_src_a_tag;
  rename_pkg::phys_tag_t         exp_src_b_tag;
  logic                          exp_src_a_ready;
  logic                          exp_src_b_ready;
  rename_pkg::phys_tag_t         exp_new_tag;
  rename_pkg::phys_tag_t         exp_old_tag;
  logic [rename_pkg::num_fu-1:0] exp_grant = '0;
  logic                          exp_cdb_valid;
  rename_pkg::phys_tag_t         exp_cdb_tag;
  logic                          exp_retire_valid;
  rename_pkg::arch_reg_t         exp_retire_arch;
  rename_pkg::phys_tag_t         exp_retire_new_tag;
  rename_pkg::phys_tag_t         exp_retire_old_tag;

  // stimulus reach
  logic saw_full = 1'b0;
  logic saw_multi_req = 1'b0;
  int   cycles = 0;

  rename_core uut (.*);

  always #10 clock = ~clock;

  ////////////////////////////////////////
  // error reporting
  ////////////////////////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    stop_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected));
  endtask

  function automatic string head_state_name();
    if (rob_st.size() == 0) begin
      return "none";
    end
    return rob_st[0].name();
  endfunction

  always @(posedge clock) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      stop_run($sformatf("run passed %0d cycles without finishing, ROB head state %s",
                         cycle_limit, head_state_name()));
    end
  end

  ////////////////////////////////////////
  // model update at the rising edge
  ////////////////////////////////////////

  task automatic reset_model();
    for (int r = 0; r < rename_pkg::num_arch_regs; r++) begin
      model_map[r] = rename_pkg::phys_tag_t'(r);
    end
    model_ready = '1;
    free_q.delete();
    for (int t = rename_pkg::num_arch_regs; t < rename_pkg::num_phys_regs; t++) begin
      free_q.push_back(rename_pkg::phys_tag_t'(t));
    end
    rob_arch.delete();
    rob_new.delete();
    rob_old.delete();
    rob_st.delete();
    pending.delete();
    model_started = 1'b0;
    exp_cdb_valid = 1'b0;
    exp_cdb_tag = '0;
    exp_retire_valid = 1'b0;
  endtask

  task automatic step_model();
    rename_pkg::phys_tag_t freed;
    logic                  do_free;
    logic                  head_leaves;
    model_started = 1'b1;
    // retire seen this cycle hands its old tag back at this edge
    do_free = exp_retire_valid;
    freed   = exp_retire_old_tag;
    // head leaves when done, or when the cdb hits it right now
    head_leaves = (rob_st.size() != 0) && ((rob_st[0] == rename_pkg::rob_done) ||
                  (exp_cdb_valid && exp_cdb_tag == rob_new[0]));
    exp_retire_valid = head_leaves;
    if (head_leaves) begin
      exp_retire_arch    = rob_arch.pop_front();
      exp_retire_new_tag = rob_new.pop_front();
      exp_retire_old_tag = rob_old.pop_front();
      void'(rob_st.pop_front());
    end
    // wakeup and completion marking
    if (exp_cdb_valid) begin
      model_ready[exp_cdb_tag] = 1'b1;
      foreach (rob_new[k]) begin
        if (rob_new[k] == exp_cdb_tag) begin
          rob_st[k] = rename_pkg::rob_done;
        end
      end
    end
    if (exp_fire) begin
      model_map[dispatch_dest] = exp_new_tag;
      model_ready[exp_new_tag] = 1'b0;
      void'(free_q.pop_front());
      rob_arch.push_back(dispatch_dest);
      rob_new.push_back(exp_new_tag);
      rob_old.push_back(exp_old_tag);
      rob_st.push_back(rename_pkg::rob_waiting);
      pending.push_back(exp_new_tag);
    end
    if (do_free) begin
      free_q.push_back(freed);
    end
    // granted tag shows on the cdb next cycle
    exp_cdb_valid = (exp_grant != '0);
    for (int i = 0; i < rename_pkg::num_fu; i++) begin
      if (exp_grant[i]) begin
        exp_cdb_tag = fu_done_tag[i];
      end
    end
  endtask

  always @(posedge clock) begin
    if (reset) begin
      reset_model();
    end else begin
      step_model();
    end
  end

  ////////////////////////////////////////
  // stimulus on the falling edge
  ////////////////////////////////////////

  task automatic drive_cycle(input int dispatch_odds, input bit complete, input int reg_span);
    int unsigned pick;
    // new request only once the last one went through
    if (!dispatch_valid || exp_fire) begin
      dispatch_valid = ($urandom_range(0, 3) < dispatch_odds);
      dispatch_dest  = rename_pkg::arch_reg_t'($urandom_range(0, reg_span - 1));
      dispatch_src_a = rename_pkg::arch_reg_t'($urandom_range(0, reg_span - 1));
      dispatch_src_b = rename_pkg::arch_reg_t'($urandom_range(0, reg_span - 1));
    end
    for (int i = 0; i < rename_pkg::num_fu; i++) begin
      // granted at the last edge, unit free again
      if (exp_grant[i]) begin
        fu_done_valid[i] = 1'b0;
      end
      // random pick shuffles completion order
      if (!fu_done_valid[i] && complete && pending.size() != 0 && $urandom_range(0, 2) == 0) begin
        pick = $urandom_range(0, pending.size() - 1);
        fu_done_tag[i] = pending[pick];
        pending.delete(pick);
        fu_done_valid[i] = 1'b1;
      end
    end
    exp_dispatch_ready = model_started && (rob_arch.size() < rename_pkg::rob_size) &&
                         (free_q.size() != 0);
    exp_fire        = dispatch_valid && exp_dispatch_ready;
    exp_src_a_tag   = model_map[dispatch_src_a];
    exp_src_b_tag   = model_map[dispatch_src_b];
    exp_src_a_ready = model_ready[exp_src_a_tag];
    exp_src_b_ready = model_ready[exp_src_b_tag];
    exp_old_tag     = model_map[dispatch_dest];
    exp_new_tag     = (free_q.size() != 0) ? free_q[0] : '0;
    // lowest requesting unit wins
    exp_grant = '0;
    for (int i = 0; i < rename_pkg::num_fu; i++) begin
      if (fu_done_valid[i] && exp_grant == '0) begin
        exp_grant[i] = 1'b1;
      end
    end
    if ($countones(fu_done_valid) > 1) begin
      saw_multi_req = 1'b1;
    end
    if (dispatch_valid && rob_arch.size() == rename_pkg::rob_size) begin
      saw_full = 1'b1;
    end
  endtask

  task automatic run_cycles(input int n, input int dispatch_odds, input bit complete,
                            input int reg_span);
    repeat (n) begin
      @(negedge clock);
      drive_cycle(dispatch_odds, complete, reg_span);
    end
  endtask

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  assert property (@(posedge clock) disable iff (reset) dispatch_ready == exp_dispatch_ready)
    else report_mismatch("dispatch_ready", $sampled(dispatch_ready), $sampled(exp_dispatch_ready));
  assert property (@(posedge clock) disable iff (reset) fu_done_ready == exp_grant)
    else report_mismatch("fu_done_ready", $sampled(fu_done_ready), $sampled(exp_grant));
  assert property (@(posedge clock) disable iff (reset) cdb_valid == exp_cdb_valid)
    else report_mismatch("cdb_valid", $sampled(cdb_valid), $sampled(exp_cdb_valid));
  assert property (@(posedge clock) disable iff (reset) exp_cdb_valid |-> cdb_tag == exp_cdb_tag)
    else report_mismatch("cdb_tag", $sampled(cdb_tag), $sampled(exp_cdb_tag));

  // retire port, in dispatch order
  assert property (@(posedge clock) disable iff (reset) retire_valid == exp_retire_valid)
    else report_mismatch("retire_valid", $sampled(retire_valid), $sampled(exp_retire_valid));
  assert property (@(posedge clock) disable iff (reset)
                   exp_retire_valid |-> retire_arch == exp_retire_arch)
    else report_mismatch("retire_arch", $sampled(retire_arch), $sampled(exp_retire_arch));
  assert property (@(posedge clock) disable iff (reset)
                   exp_retire_valid |-> retire_new_tag == exp_retire_new_tag)
    else report_mismatch("retire_new_tag", $sampled(retire_new_tag),
                         $sampled(exp_retire_new_tag));
  assert property (@(posedge clock) disable iff (reset)
                   exp_retire_valid |-> retire_old_tag == exp_retire_old_tag)
    else report_mismatch("retire_old_tag", $sampled(retire_old_tag),
                         $sampled(exp_retire_old_tag));

  // rename results, only on a transfer
  assert property (@(posedge clock) disable iff (reset) exp_fire |-> new_tag == exp_new_tag)
    else report_mismatch("new_tag", $sampled(new_tag), $sampled(exp_new_tag));
  assert property (@(posedge clock) disable iff (reset) exp_fire |-> old_tag == exp_old_tag)
    else report_mismatch("old_tag", $sampled(old_tag), $sampled(exp_old_tag));
  assert property (@(posedge clock) disable iff (reset) exp_fire |-> src_a_tag == exp_src_a_tag)
    else report_mismatch("src_a_tag", $sampled(src_a_tag), $sampled(exp_src_a_tag));
  assert property (@(posedge clock) disable iff (reset) exp_fire |-> src_b_tag == exp_src_b_tag)
    else report_mismatch("src_b_tag", $sampled(src_b_tag), $sampled(exp_src_b_tag));
  assert property (@(posedge clock) disable iff (reset)
                   exp_fire |-> src_a_ready == exp_src_a_ready)
    else report_mismatch("src_a_ready", $sampled(src_a_ready), $sampled(exp_src_a_ready));
  assert property (@(posedge clock) disable iff (reset)
                   exp_fire |-> src_b_ready == exp_src_b_ready)
    else report_mismatch("src_b_ready", $sampled(src_b_ready), $sampled(exp_src_b_ready));

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    void'($urandom(64));
    clock          = 1'b0;
    reset          = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_dest  = '0;
    dispatch_src_a = '0;
    dispatch_src_b = '0;
    fu_done_valid  = '0;
    for (int i = 0; i < rename_pkg::num_fu; i++) begin
      fu_done_tag[i] = '0;
    end
    repeat (8) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    drive_cycle(0, 1'b0, 1);
    // few registers, so chains of dependent renames
    run_cycles(200, 3, 1'b1, 8);
    // no new completions, dispatch held until the rob fills
    run_cycles(40, 4, 1'b0, rename_pkg::num_arch_regs);
    // long mixed run, freed tags come around again
    run_cycles(300, 3, 1'b1, rename_pkg::num_arch_regs);
    // drain everything still in flight
    while (rob_arch.size() != 0) begin
      run_cycles(1, 0, 1'b1, rename_pkg::num_arch_regs);
    end
    run_cycles(4, 0, 1'b1, rename_pkg::num_arch_regs);
    if (saw_full && saw_multi_req) begin
      $display("Everything OK");
      $finish;
    end else begin
      stop_run("stimulus never filled the ROB or never had competing completions");
    end
  end

endmodule

`default_nettype wire

// ==== logic/rename_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module rename_core (
  input  logic                          clock,
  input  logic                          reset,
  // dispatch
  input  logic                          dispatch_valid,
  output logic                          dispatch_ready,
  input  rename_pkg::arch_reg_t         dispatch_dest,
  input  rename_pkg::arch_reg_t         dispatch_src_a,
  input  rename_pkg::arch_reg_t         dispatch_src_b,
  // rename results, same cycle as dispatch
  output rename_pkg::phys_tag_t         src_a_tag,
  output rename_pkg::phys_tag_t         src_b_tag,
  output logic                          src_a_ready,
  output logic                          src_b_ready,
  output rename_pkg::phys_tag_t         new_tag,
  output rename_pkg::phys_tag_t         old_tag,
  // completions
  input  logic [rename_pkg::num_fu-1:0] fu_done_valid,
  input  rename_pkg::phys_tag_t         fu_done_tag [rename_pkg::num_fu],
  output logic [rename_pkg::num_fu-1:0] fu_done_ready,
  // common data bus
  output logic                          cdb_valid,
  output rename_pkg::phys_tag_t         cdb_tag,
  // retire
  output logic                          retire_valid,
  output rename_pkg::arch_reg_t         retire_arch,
  output rename_pkg::phys_tag_t         retire_new_tag,
  output rename_pkg::phys_tag_t         retire_old_tag
);

  logic rob_full;
  logic fl_empty;
  logic fire;

  // low for one cycle out of reset
  logic started;

  always_ff @(posedge clock) begin
    if (reset) begin
      started <= 1'b0;
    end else begin
      started <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // dispatch handshake
  ////////////////////////////////////////

  // need a rob slot and a free tag
  assign dispatch_ready = started && !rob_full && !fl_empty;
  assign fire           = dispatch_valid && dispatch_ready;

  map_table u_map_table (
    .clock       (clock),
    .reset       (reset),
    .rename_en   (fire),
    .dest        (dispatch_dest),
    .src_a       (dispatch_src_a),
    .src_b       (dispatch_src_b),
    .new_tag     (new_tag),
    .cdb_valid   (cdb_valid),
    .cdb_tag     (cdb_tag),
    .src_a_tag   (src_a_tag),
    .src_b_tag   (src_b_tag),
    .old_tag     (old_tag),
    .src_a_ready (src_a_ready),
    .src_b_ready (src_b_ready)
  );

  // retired old tags come back through the tail
  free_list u_free_list (
    .clock    (clock),
    .reset    (reset),
    .pop      (fire),
    .push     (retire_valid),
    .push_tag (retire_old_tag),
    .head_tag (new_tag),
    .empty    (fl_empty)
  );

  reorder_buffer u_reorder_buffer (
    .clock          (clock),
    .reset          (reset),
    .alloc          (fire),
    .alloc_arch     (dispatch_dest),
    .alloc_new_tag  (new_tag),
    .alloc_old_tag  (old_tag),
    .cdb_valid      (cdb_valid),
    .cdb_tag        (cdb_tag),
    .full           (rob_full),
    .retire_valid   (retire_valid),
    .retire_arch    (retire_arch),
    .retire_new_tag (retire_new_tag),
    .retire_old_tag (retire_old_tag)
  );

  completion_select u_completion_select (
    .clock         (clock),
    .reset         (reset),
    .fu_done_valid (fu_done_valid),
    .fu_done_tag   (fu_done_tag),
    .fu_done_ready (fu_done_ready),
    .cdb_valid     (cdb_valid),
    .cdb_tag       (cdb_tag)
  );

endmodule

`default_nettype wire

// ==== logic/completion_select.sv ====
`timescale 1ns/100ps
`default_nettype none

module completion_select (
  input  logic                          clock,
  input  logic                          reset,
  input  logic [rename_pkg::num_fu-1:0] fu_done_valid,
  input  rename_pkg::phys_tag_t         fu_done_tag [rename_pkg::num_fu],
  output logic [rename_pkg::num_fu-1:0] fu_done_ready,
  output logic                          cdb_valid,
  output rename_pkg::phys_tag_t         cdb_tag
);

  // granted unit index
  rename_pkg::fu_sel_t sel;

  // some unit is asking
  logic any_req;

  ////////////////////////////////////////
  // fixed priority where the lowest index wins
  ////////////////////////////////////////

  always_comb begin
    sel     = '0;
    any_req = 1'b0;
    // scan downward so the lowest requester is the last to write
    for (int i = rename_pkg::num_fu - 1; i >= 0; i--) begin
      if (fu_done_valid[i]) begin
        sel     = rename_pkg::fu_sel_t'(i);
        any_req = 1'b1;
      end
    end
  end

  // one-hot grant back to the units
  always_comb begin
    for (int i = 0; i < rename_pkg::num_fu; i++) begin
      fu_done_ready[i] = any_req && (sel == rename_pkg::fu_sel_t'(i));
    end
  end

  ////////////////////////////////////////
  // cdb register
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= any_req;
    end
  end

  // granted unit's tag onto the bus
  always_ff @(posedge clock) begin
    cdb_tag <= fu_done_tag[sel];
  end

endmodule

`default_nettype wire

// ==== logic/reorder_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  alloc,
  input  rename_pkg::arch_reg_t alloc_arch,
  input  rename_pkg::phys_tag_t alloc_new_tag,
  input  rename_pkg::phys_tag_t alloc_old_tag,
  input  logic                  cdb_valid,
  input  rename_pkg::phys_tag_t cdb_tag,
  output logic                  full,
  output logic                  retire_valid,
  output rename_pkg::arch_reg_t retire_arch,
  output rename_pkg::phys_tag_t retire_new_tag,
  output rename_pkg::phys_tag_t retire_old_tag
);

  // per entry state
  rename_pkg::rob_state_t state [rename_pkg::rob_size];

  // per entry payload
  rename_pkg::arch_reg_t arch_q    [rename_pkg::rob_size];
  rename_pkg::phys_tag_t new_tag_q [rename_pkg::rob_size];
  rename_pkg::phys_tag_t old_tag_q [rename_pkg::rob_size];

  // oldest entry and next free slot
  rename_pkg::rob_ptr_t head;
  rename_pkg::rob_ptr_t tail;

  // occupancy, 0 .. rob_size
  logic [$clog2(rename_pkg::rob_size):0] count;

  // head leaves at this edge
  logic head_done;

  ////////////////////////////////////////
  // retire decision
  ////////////////////////////////////////

  // a cdb hit on the head retires right away,
  // gives the one cycle cdb to retire path
  assign head_done = (state[head] == rename_pkg::rob_done) ||
                     ((state[head] == rename_pkg::rob_waiting) &&
                      cdb_valid && (cdb_tag == new_tag_q[head]));

  assign full = (count == ($clog2(rename_pkg::rob_size) + 1)'(rename_pkg::rob_size));

  ////////////////////////////////////////
  // control
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < rename_pkg::rob_size; i++) begin
        state[i] <= rename_pkg::rob_empty;
      end
      head         <= '0;
      tail         <= '0;
      count        <= '0;
      retire_valid <= 1'b0;
    end else begin
      // cam on new tag, only one in-flight entry can match
      if (cdb_valid) begin
        for (int i = 0; i < rename_pkg::rob_size; i++) begin
          if (state[i] == rename_pkg::rob_waiting && new_tag_q[i] == cdb_tag) begin
            state[i] <= rename_pkg::rob_done;
          end
        end
      end
      // caller keeps alloc low while full
      if (alloc) begin
        state[tail] <= rename_pkg::rob_waiting;
        tail        <= tail + 1'b1;
      end
      // later assignment wins over the cam mark above
      if (head_done) begin
        state[head] <= rename_pkg::rob_empty;
        head        <= head + 1'b1;
      end
      retire_valid <= head_done;
      if (alloc && !head_done) begin
        count <= count + 1'b1;
      end else if (head_done && !alloc) begin
        count <= count - 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // payload
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (alloc) begin
      arch_q[tail]    <= alloc_arch;
      new_tag_q[tail] <= alloc_new_tag;
      old_tag_q[tail] <= alloc_old_tag;
    end
    // retire port holds its last values between retirements
    if (head_done) begin
      retire_arch    <= arch_q[head];
      retire_new_tag <= new_tag_q[head];
      retire_old_tag <= old_tag_q[head];
    end
  end

endmodule

`default_nettype wire

// ==== logic/free_list.sv ====
`timescale 1ns/100ps
`default_nettype none

module free_list (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  pop,
  input  logic                  push,
  input  rename_pkg::phys_tag_t push_tag,
  output rename_pkg::phys_tag_t head_tag,
  output logic                  empty
);

  // circular buffer of unbound tags
  rename_pkg::phys_tag_t tags [rename_pkg::free_list_size];

  // size is a power of two so the pointers wrap on their own
  logic [$clog2(rename_pkg::free_list_size)-1:0] head;
  logic [$clog2(rename_pkg::free_list_size)-1:0] tail;

  // 0 .. free_list_size, one extra bit for full
  logic [$clog2(rename_pkg::free_list_size):0] count;

  ////////////////////////////////////////
  // outputs
  ////////////////////////////////////////

  // next tag to hand out, valid when not empty
  assign head_tag = tags[head];
  assign empty    = (count == '0);

  ////////////////////////////////////////
  // pointers and count
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      // starts full, tail wrapped onto head
      head  <= '0;
      tail  <= '0;
      count <= ($clog2(rename_pkg::free_list_size) + 1)'(rename_pkg::free_list_size);
    end else begin
      if (pop) begin
        head <= head + 1'b1;
      end
      if (push) begin
        tail <= tail + 1'b1;
      end
      // net change of one at most
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      // tags above the arch range, ascending
      for (int i = 0; i < rename_pkg::free_list_size; i++) begin
        tags[i] <= rename_pkg::phys_tag_t'(rename_pkg::num_arch_regs + i);
      end
    end else if (push) begin
      // freed tags queue behind the ones still unused
      tags[tail] <= push_tag;
    end
  end

endmodule

`default_nettype wire

// ==== logic/map_table.sv ====
`timescale 1ns/100ps
`default_nettype none

module map_table (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  rename_en,
  input  rename_pkg::arch_reg_t dest,
  input  rename_pkg::arch_reg_t src_a,
  input  rename_pkg::arch_reg_t src_b,
  input  rename_pkg::phys_tag_t new_tag,
  input  logic                  cdb_valid,
  input  rename_pkg::phys_tag_t cdb_tag,
  output rename_pkg::phys_tag_t src_a_tag,
  output rename_pkg::phys_tag_t src_b_tag,
  output rename_pkg::phys_tag_t old_tag,
  output logic                  src_a_ready,
  output logic                  src_b_ready
);

  // arch reg -> current phys tag
  rename_pkg::phys_tag_t map [rename_pkg::num_arch_regs];

  // one bit per phys tag, set once its value is on the cdb
  logic [rename_pkg::num_phys_regs-1:0] ready;

  ////////////////////////////////////////
  // lookup
  ////////////////////////////////////////

  // reads see the table before this edge's update
  assign src_a_tag = map[src_a];
  assign src_b_tag = map[src_b];
  assign old_tag   = map[dest];

  // ready from registered bits only, no cdb bypass
  assign src_a_ready = ready[map[src_a]];
  assign src_b_ready = ready[map[src_b]];

  ////////////////////////////////////////
  // update
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity map, every value already available
      for (int r = 0; r < rename_pkg::num_arch_regs; r++) begin
        map[r] <= rename_pkg::phys_tag_t'(r);
      end
      ready <= '1;
    end else begin
      // broadcast wakes up the tag
      if (cdb_valid) begin
        ready[cdb_tag] <= 1'b1;
      end
      // new_tag comes off the free list, never equal to cdb_tag
      if (rename_en) begin
        map[dest]      <= new_tag;
        ready[new_tag] <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

  ////////////////////////////////////////
  // sizes
  ////////////////////////////////////////

  // architectural registers, all renamed
  localparam int num_arch_regs = 32;

  // physical register tags
  localparam int num_phys_regs = 64;

  // in-flight window
  localparam int rob_size = 16;

  // tags not bound to an arch reg at reset
  localparam int free_list_size = num_phys_regs - num_arch_regs;

  // units reporting completions
  localparam int num_fu = 4;

  ////////////////////////////////////////
  // types
  ////////////////////////////////////////

  typedef logic [4:0] arch_reg_t;
  typedef logic [5:0] phys_tag_t;
  typedef logic [3:0] rob_ptr_t;
  typedef logic [1:0] fu_sel_t;

  // rob entry life cycle
  // empty -> waiting on dispatch, waiting -> done on cdb hit
  typedef enum logic [1:0] {
    rob_empty   = 2'd0,
    rob_waiting = 2'd1,
    rob_done    = 2'd2
  } rob_state_t;

endpackage

`default_nettype wire
